// File: adcCfgPkg.sv
`include "adcCfg_consts.svh"

package adcCfgPkg;

	// register word as shifted to the adc
	typedef logic [`ADC_WORD_W-1:0] adcWord_t;
	typedef logic [`ADC_ENTRY_W-1:0] romEntry_t; // rom index

	// wishbone side
	typedef logic [`WB_DATA_W-1:0] wbData_t;
	typedef logic [`WB_ADDR_W-1:0] wbAddr_t;

	typedef logic [`SEQ_COUNT_W-1:0] seqCount_t; // wraps at 255
	typedef logic [1:0] seqKind_t; // one of the SEQ_KIND codes

	// sequencer states
	typedef enum logic [2:0] {
		IDLE,      // waiting for a command
		LOAD,      // first entry and word count set up
		SEND,      // word offered to the shifter
		WAIT_WORD, // shifter busy with the word
		FINISH     // done strobe
	} seqState_t;

endpackage

// File: adcCfgRegDecode.sv
`timescale 1ns/10ps
`include "adcCfg_consts.svh"

// wishbone classic slave, command and status registers
module adcCfgRegDecode (
	input  logic                clk,
	input  logic                rst,
	input  logic                wbCyc,
	input  logic                wbStb,
	input  logic                wbWe,
	input  adcCfgPkg::wbAddr_t  wbAdr,
	input  adcCfgPkg::wbData_t  wbDatIn,
	output adcCfgPkg::wbData_t  wbDatOut,
	output logic                wbAck,
	input  adcCfgPkg::wbData_t  statusWord,
	output logic                cmdValid,
	output adcCfgPkg::seqKind_t cmdKind,
	output logic                clearReject
);

	logic req;                     // new access, not yet acked
	logic isCmd, isStatus;
	logic cmdHit;                  // some command bit set
	adcCfgPkg::seqKind_t kindNext;

	assign req      = wbCyc & wbStb & ~wbAck; // ack cycle itself is not a new request
	assign isCmd    = (wbAdr == adcCfgPkg::wbAddr_t'(`WB_ADDR_CMD));
	assign isStatus = (wbAdr == adcCfgPkg::wbAddr_t'(`WB_ADDR_STATUS));

	// command priority: init, then des enable, then des disable
	always_comb begin
		cmdHit   = 1'b1;
		kindNext = `SEQ_KIND_DES_DIS;
		if (wbDatIn[`CMD_INIT_BIT])
			kindNext = `SEQ_KIND_INIT;
		else if (wbDatIn[`CMD_DES_EN_BIT])
			kindNext = `SEQ_KIND_DES_EN;
		else if (!wbDatIn[`CMD_DES_DIS_BIT])
			cmdHit = 1'b0; // no bit, no command
	end

	////////////////////
	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			wbAck       <= 1'b0;
			cmdValid    <= 1'b0;
			clearReject <= 1'b0;
		end else begin
			wbAck       <= req; // one clock after the request
			cmdValid    <= req & wbWe & isCmd & cmdHit;
			clearReject <= req & wbWe & isStatus & wbDatIn[`STAT_REJECT_BIT];
		end
	end

	// read data and kind, valid only alongside ack / cmdValid
	always_ff @(posedge clk) begin
		cmdKind  <= kindNext;
		wbDatOut <= (req & ~wbWe & isStatus) ? statusWord : '0; // cmd reads as zero
	end

	// host drops the strobe once it has seen the ack
	strobeAfterAck: assert property (@(posedge clk) disable iff (rst) wbAck |=> !wbStb);

endmodule

// File: adcCfgRom.sv
`timescale 1ns/10ps
`include "adcCfg_consts.svh"

// fixed table of adc register words
module adcCfgRom (
	input  adcCfgPkg::romEntry_t entry,
	output adcCfgPkg::adcWord_t  word
);

	always_comb begin
		case (entry)
			4'd0:    word = `ADC_ROM_0;
			4'd1:    word = `ADC_ROM_1;
			4'd2:    word = `ADC_ROM_2;
			4'd3:    word = `ADC_ROM_3;
			4'd4:    word = `ADC_ROM_4;
			4'd5:    word = `ADC_ROM_5; // also used by des disable
			4'd6:    word = `ADC_ROM_6;
			4'd7:    word = `ADC_ROM_7;
			4'd8:    word = `ADC_ROM_8; // des enable
			4'd9:    word = `ADC_ROM_9;
			default: word = '0; // unused slots
		endcase
	end

endmodule

// File: adcCfgSequencer.sv
`timescale 1ns/10ps
`include "adcCfg_consts.svh"

// walks rom entries of one sequence and feeds the shifter
module adcCfgSequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                cmdValid,
	input  adcCfgPkg::seqKind_t cmdKind,
	input  logic                wordDone,
	output logic                wordValid,
	output adcCfgPkg::adcWord_t word,
	output logic                busy,
	output logic                seqDone
);

	adcCfgPkg::seqState_t state;
	adcCfgPkg::seqKind_t  kindReg;   // latched command kind
	adcCfgPkg::romEntry_t entry;     // current rom index
	logic [3:0]           wordsLeft; // including the one in flight

	// rom output goes straight to the shifter, entry is stable in SEND
	adcCfgRom i_adcCfgRom (
		.entry (entry),
		.word  (word)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= adcCfgPkg::IDLE;
			kindReg   <= `SEQ_KIND_INIT;
			entry     <= '0;
			wordsLeft <= '0;
			wordValid <= 1'b0;
			busy      <= 1'b0;
			seqDone   <= 1'b0;
		end else begin
			wordValid <= 1'b0;
			seqDone   <= 1'b0;
			case (state)
				adcCfgPkg::IDLE: begin
					if (cmdValid) begin // busy is low here, command taken
						kindReg <= cmdKind;
						busy    <= 1'b1;
						state   <= adcCfgPkg::LOAD;
					end
				end
				adcCfgPkg::LOAD: begin
					case (kindReg)
						`SEQ_KIND_INIT: begin // full write, entries 0..7
							entry     <= adcCfgPkg::romEntry_t'(0);
							wordsLeft <= 4'd8;
						end
						`SEQ_KIND_DES_EN: begin
							entry     <= adcCfgPkg::romEntry_t'(8);
							wordsLeft <= 4'd1;
						end
						default: begin // des disable, resend entry 5
							entry     <= adcCfgPkg::romEntry_t'(5);
							wordsLeft <= 4'd1;
						end
					endcase
					wordValid <= 1'b1; // high during SEND
					state     <= adcCfgPkg::SEND;
				end
				adcCfgPkg::SEND: state <= adcCfgPkg::WAIT_WORD; // shifter took the word
				adcCfgPkg::WAIT_WORD: begin
					if (wordDone) begin
						if (wordsLeft == 4'd1) begin
							seqDone <= 1'b1; // one clock after the last wordDone
							state   <= adcCfgPkg::FINISH;
						end else begin
							entry     <= entry + 1'b1;
							wordsLeft <= wordsLeft - 1'b1;
							wordValid <= 1'b1;
							state     <= adcCfgPkg::SEND;
						end
					end
				end
				adcCfgPkg::FINISH: begin
					busy  <= 1'b0;
					state <= adcCfgPkg::IDLE;
				end
				default: state <= adcCfgPkg::IDLE;
			endcase
		end
	end

	// shifter only finishes a word the sequencer is waiting on
	wordDoneInWait: assert property (@(posedge clk) disable iff (rst)
		wordDone |-> state == adcCfgPkg::WAIT_WORD);

endmodule

// File: adcCfgStatus.sv
`timescale 1ns/10ps
`include "adcCfg_consts.svh"

// busy, done, reject and sequence count behind the status register
module adcCfgStatus (
	input  logic               clk,
	input  logic               rst,
	input  logic               cmdValid,
	input  logic               busy,
	input  logic               seqDone,
	input  logic               clearReject,
	output adcCfgPkg::wbData_t statusWord
);

	logic                 doneFlag;
	logic                 rejectFlag; // sticky until cleared by the host
	adcCfgPkg::seqCount_t seqCount;

	always_ff @(posedge clk) begin
		if (rst) begin
			doneFlag   <= 1'b0;
			rejectFlag <= 1'b0;
			seqCount   <= '0;
		end else begin
			if (seqDone)
				doneFlag <= 1'b1;
			else if (cmdValid && !busy)
				doneFlag <= 1'b0; // next command accepted
			if (cmdValid && busy)
				rejectFlag <= 1'b1; // a new reject wins over a clear
			else if (clearReject)
				rejectFlag <= 1'b0;
			if (seqDone)
				seqCount <= seqCount + 1'b1; // wraps at 255
		end
	end

	// pack status fields
	always_comb begin
		statusWord                   = '0;
		statusWord[`STAT_BUSY_BIT]   = busy;
		statusWord[`STAT_DONE_BIT]   = doneFlag;
		statusWord[`STAT_REJECT_BIT] = rejectFlag;
		statusWord[`STAT_COUNT_LSB +: `SEQ_COUNT_W] = seqCount;
	end

endmodule

// File: adcCfgTb.sv
`timescale 1ns/10ps
`include "adcCfg_consts.svh"

module adcCfgTb;

	localparam int NTEST   = 6;
	localparam int MAX_GAP = 15; // idle clocks between table entries

	typedef struct {
		adcCfgPkg::wbData_t cmd;
		logic [31:0]        idxList; // rom indices, first one in the low nibble
		int                 nWords;
		adcCfgPkg::wbData_t busyCmd; // written while busy, zero for none
		string              name;
	} testEntry_t;

	testEntry_t tests [NTEST] = '{
		'{32'h1, 32'h7654_3210, 8, 32'h0, "initWrite"},
		'{32'h2, 32'h0000_0008, 1, 32'h0, "desEnable"},
		'{32'h4, 32'h0000_0005, 1, 32'h0, "desDisable"},
		'{32'h7, 32'h7654_3210, 8, 32'h0, "prioInit"},  // init wins over both des bits
		'{32'h6, 32'h0000_0008, 1, 32'h0, "prioDesEn"}, // enable wins over disable
		'{32'h4, 32'h0000_0005, 1, 32'h1, "rejectBusy"}
	};

	// register words as listed for the adc
	adcCfgPkg::adcWord_t romModel [10] = '{`ADC_ROM_0, `ADC_ROM_1, `ADC_ROM_2, `ADC_ROM_3,
		`ADC_ROM_4, `ADC_ROM_5, `ADC_ROM_6, `ADC_ROM_7, `ADC_ROM_8, `ADC_ROM_9};

	logic clk, rst, wbCyc, wbStb, wbWe, wbAck, sclk, sdata, select, done;
	adcCfgPkg::wbAddr_t  wbAdr;
	adcCfgPkg::wbData_t  wbDatIn, wbDatOut;
	adcCfgPkg::adcWord_t rxWords [$]; // decoded serial frames
	adcCfgPkg::adcWord_t frame;
	int bitCnt, doneCount, mismatchCount, failCount, cycles, limit;
	logic prevSclk, prevSel, prevDone;

	tbClockGen i_tbClockGen (.clk(clk), .rst(rst));

	adcCfgTop i_adcCfgTop (
		.clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
		.sclk(sclk), .sdata(sdata), .select(select), .done(done)
	);

	////////////////////
	// compare tasks
	task automatic checkWord(input string name, input adcCfgPkg::adcWord_t exp,
		input adcCfgPkg::adcWord_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			mismatchCount++;
		end
	endtask

	task automatic checkData(input string name, input adcCfgPkg::wbData_t exp,
		input adcCfgPkg::wbData_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			mismatchCount++;
		end
	endtask

	task automatic checkCount(input string name, input adcCfgPkg::seqCount_t exp,
		input adcCfgPkg::seqCount_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
			mismatchCount++;
		end
	endtask

	// one classic access, strobe held until the ack
	task automatic wbAccess(input adcCfgPkg::wbAddr_t adr, input logic we,
		input adcCfgPkg::wbData_t dat, output adcCfgPkg::wbData_t rdat);
		int waitCnt;
		@(posedge clk);
		wbCyc   <= 1'b1;
		wbStb   <= 1'b1;
		wbWe    <= we;
		wbAdr   <= adr;
		wbDatIn <= dat;
		waitCnt = 0;
		do begin
			@(posedge clk);
			waitCnt++;
		end while (!wbAck && waitCnt < 8);
		if (!wbAck) begin
			$display("no wbAck for the access to address %0d", adr);
			failCount++;
		end
		rdat = wbDatOut; // registered alongside the ack
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
		@(posedge clk);
		if (wbAck) begin
			$display("wbAck stayed high for a second clock at address %0d", adr);
			failCount++;
		end
	endtask

	////////////////////
	// serial frame decoder and done watcher
	always @(posedge clk) begin
		prevSclk <= sclk;
		prevSel  <= select;
		prevDone <= done;
		if (rst) begin
			bitCnt <= 0;
		end else if (!select && sclk && !prevSclk) begin // adc samples on sclk rise
			frame  <= {frame[`ADC_WORD_W-2:0], sdata};
			bitCnt <= bitCnt + 1;
		end else if (select && !prevSel) begin // frame closed
			if (bitCnt != `ADC_WORD_W) begin
				$display("serial frame closed after %0d bits", bitCnt);
				failCount++;
			end
			rxWords.push_back(frame);
			bitCnt <= 0;
		end
		if (!rst && done) begin
			doneCount <= doneCount + 1;
			if (prevDone) begin
				$display("done strobe lasted more than one clock");
				failCount++;
			end
		end
	end

	// run limit from the table length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("timeout after %0d clocks, a sequence never finished", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		int gap;
		int startDone;
		adcCfgPkg::wbData_t rdat;
		adcCfgPkg::wbData_t expStat;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatIn = '0;
		frame = '0;
		doneCount = 0;
		mismatchCount = 0;
		failCount = 0;
		cycles = 0;
		limit = 0;
		for (int i = 0; i < NTEST; i++)
			limit += tests[i].nWords * (`ADC_WORD_W * `ADC_SCLK_DIV + `ADC_WORD_GAP + 4);
		limit = limit * 3 / 2 + NTEST * (200 + MAX_GAP);
		void'($urandom(32'hbb9ce13c)); // seeds the generator once
		do begin
			@(posedge clk);
		end while (rst);
		if (select !== 1'b1 || done !== 1'b0) begin
			$display("select not high or done not low after reset");
			failCount++;
		end
		wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_STATUS), 1'b0, '0, rdat);
		checkData("resetStatus", '0, rdat);
		for (int i = 0; i < NTEST; i++) begin
			startDone = doneCount; // stray pulses in the gap count against this entry
			gap = $urandom_range(MAX_GAP, 0);
			repeat (gap) @(posedge clk);
			wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_CMD), 1'b1, tests[i].cmd, rdat);
			if (tests[i].busyCmd != '0) begin
				wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_CMD), 1'b1, tests[i].busyCmd, rdat);
				wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_STATUS), 1'b0, '0, rdat);
				expStat = '0; // busy and rejected, done cleared by the accepted command
				expStat[`STAT_BUSY_BIT] = 1'b1;
				expStat[`STAT_REJECT_BIT] = 1'b1;
				expStat[`STAT_COUNT_LSB +: `SEQ_COUNT_W] = adcCfgPkg::seqCount_t'(i);
				checkData({tests[i].name, " busyStatus"}, expStat, rdat);
			end
			while (doneCount == startDone) @(posedge clk);
			if (tests[i].busyCmd != '0) // room for any word a rejected command might send
				repeat (`ADC_WORD_W * `ADC_SCLK_DIV + 100) @(posedge clk);
			checkCount({tests[i].name, " words"}, adcCfgPkg::seqCount_t'(tests[i].nWords),
				adcCfgPkg::seqCount_t'(rxWords.size()));
			for (int k = 0; k < tests[i].nWords && k < rxWords.size(); k++)
				checkWord(tests[i].name, romModel[tests[i].idxList[4*k +: 4]], rxWords[k]);
			rxWords.delete();
			wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_STATUS), 1'b0, '0, rdat);
			checkCount({tests[i].name, " donePulses"}, 8'd1,
				adcCfgPkg::seqCount_t'(doneCount - startDone));
			expStat = '0;
			expStat[`STAT_DONE_BIT] = 1'b1;
			expStat[`STAT_REJECT_BIT] = (tests[i].busyCmd != '0);
			expStat[`STAT_COUNT_LSB +: `SEQ_COUNT_W] = adcCfgPkg::seqCount_t'(i + 1);
			checkData({tests[i].name, " status"}, expStat, rdat);
			if (tests[i].busyCmd != '0) begin // clear the sticky reject
				wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_STATUS), 1'b1,
					32'h1 << `STAT_REJECT_BIT, rdat);
				wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_STATUS), 1'b0, '0, rdat);
				expStat[`STAT_REJECT_BIT] = 1'b0;
				checkData({tests[i].name, " clearedStatus"}, expStat, rdat);
			end
		end
		// status is nonzero by now, so a cmd read must not return it
		wbAccess(adcCfgPkg::wbAddr_t'(`WB_ADDR_CMD), 1'b0, '0, rdat);
		checkData("cmdRead", '0, rdat);
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: adcCfgTop.f
+incdir+.
adcCfgPkg.sv
adcCfgRom.sv
adcCfgRegDecode.sv
adcCfgSequencer.sv
adcSerialShifter.sv
adcCfgStatus.sv
adcCfgTop.sv
tbClockGen.sv
adcCfgTb.sv

// File: adcCfgTop.sv
`timescale 1ns/10ps

module adcCfgTop (
	input  logic               clk,
	input  logic               rst,
	input  logic               wbCyc,
	input  logic               wbStb,
	input  logic               wbWe,
	input  adcCfgPkg::wbAddr_t wbAdr,
	input  adcCfgPkg::wbData_t wbDatIn,
	output adcCfgPkg::wbData_t wbDatOut,
	output logic               wbAck,
	output logic               sclk,
	output logic               sdata,
	output logic               select,
	output logic               done
);

	adcCfgPkg::wbData_t  statusWord;
	adcCfgPkg::seqKind_t cmdKind;
	adcCfgPkg::adcWord_t word;
	logic cmdValid, clearReject, busy;
	logic wordValid, wordDone;

	adcCfgRegDecode i_adcCfgRegDecode (
		.clk(clk), .rst(rst),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
		.statusWord(statusWord),
		.cmdValid(cmdValid), .cmdKind(cmdKind), .clearReject(clearReject)
	);

	adcCfgSequencer i_adcCfgSequencer (
		.clk(clk), .rst(rst),
		.cmdValid(cmdValid), .cmdKind(cmdKind),
		.wordDone(wordDone), .wordValid(wordValid), .word(word),
		.busy(busy), .seqDone(done) // seqDone is the top level strobe
	);

	adcSerialShifter i_adcSerialShifter (
		.clk(clk), .rst(rst),
		.wordValid(wordValid), .word(word),
		.sclk(sclk), .sdata(sdata), .select(select), .wordDone(wordDone)
	);

	adcCfgStatus i_adcCfgStatus (
		.clk(clk), .rst(rst),
		.cmdValid(cmdValid), .busy(busy), .seqDone(done),
		.clearReject(clearReject), .statusWord(statusWord)
	);

endmodule

// File: adcCfg_consts.svh
`ifndef ADC_CFG_CONSTS_SVH
`define ADC_CFG_CONSTS_SVH

////////////////////
// widths
`define ADC_WORD_W      32 // bits per serial register word
`define ADC_ENTRY_W     4  // rom index
`define WB_DATA_W       32
`define WB_ADDR_W       2  // word addressed
`define SEQ_COUNT_W     8  // completed sequence counter

////////////////////
// serial timing
`define ADC_SCLK_DIV    16 // clk per sclk period, keep a power of two
`define ADC_WORD_GAP    8  // clk with select high between words

////////////////////
// bus map
`define WB_ADDR_CMD     0
`define WB_ADDR_STATUS  1
`define CMD_INIT_BIT    0
`define CMD_DES_EN_BIT  1
`define CMD_DES_DIS_BIT 2
`define STAT_BUSY_BIT   0
`define STAT_DONE_BIT   1
`define STAT_REJECT_BIT 2
`define STAT_COUNT_LSB  8 // count field is 15:8

// sequence codes, decode to sequencer
`define SEQ_KIND_INIT    2'd0
`define SEQ_KIND_DES_EN  2'd1
`define SEQ_KIND_DES_DIS 2'd2

// adc register words, address in the top bits
`define ADC_ROM_0 32'h0001_B2FF
`define ADC_ROM_1 32'h0011_07FF
`define ADC_ROM_2 32'h0021_0000
`define ADC_ROM_3 32'h0031_007F
`define ADC_ROM_4 32'h0041_0000
`define ADC_ROM_5 32'h0051_807F // des off
`define ADC_ROM_6 32'h0061_0000
`define ADC_ROM_7 32'h0071_FFFF
`define ADC_ROM_8 32'h0051_C07F // same register as entry 5, des on
`define ADC_ROM_9 32'h0071_0000 // spare

`endif

// File: adcSerialShifter.sv
`timescale 1ns/10ps
`include "adcCfg_consts.svh"

// msb first shifter with sclk divider and select framing
module adcSerialShifter (
	input  logic                clk,
	input  logic                rst,
	input  logic                wordValid,
	input  adcCfgPkg::adcWord_t word,
	output logic                sclk,
	output logic                sdata,
	output logic                select,   // active low
	output logic                wordDone
);

	localparam int DIV_W = $clog2(`ADC_SCLK_DIV);
	localparam int BIT_W = $clog2(`ADC_WORD_W);
	localparam int GAP_W = $clog2(`ADC_WORD_GAP + 1);

	logic [DIV_W-1:0]    divCnt;   // position inside one sclk period
	logic [BIT_W-1:0]    bitCnt;   // bits still to go after the current one
	logic [GAP_W-1:0]    gapCnt;
	logic                inGap;
	logic                periodEnd;
	adcCfgPkg::adcWord_t shiftReg;

	assign periodEnd = ~select & (&divCnt); // divider is a power of two
	assign sclk      = divCnt[DIV_W-1];     // rises mid period
	assign sdata     = shiftReg[`ADC_WORD_W-1];

	////////////////////
	// framing
	always_ff @(posedge clk) begin
		if (rst) begin
			select   <= 1'b1;
			inGap    <= 1'b0;
			wordDone <= 1'b0;
			divCnt   <= '0;
			bitCnt   <= '0;
			gapCnt   <= '0;
		end else begin
			wordDone <= 1'b0;
			if (wordValid) begin
				select <= 1'b0; // start of the first bit period
				divCnt <= '0;
				bitCnt <= BIT_W'(`ADC_WORD_W - 1);
			end else if (!select) begin
				divCnt <= divCnt + 1'b1; // wraps back to 0 at period end
				if (periodEnd) begin
					if (bitCnt == '0) begin // last bit out
						select <= 1'b1;
						inGap  <= 1'b1;
						gapCnt <= GAP_W'(`ADC_WORD_GAP - 1);
					end else
						bitCnt <= bitCnt - 1'b1;
				end
			end else if (inGap) begin
				if (gapCnt == '0) begin
					inGap    <= 1'b0;
					wordDone <= 1'b1;
				end else
					gapCnt <= gapCnt - 1'b1;
			end
		end
	end

	// data path, sdata moves while sclk is low
	always_ff @(posedge clk) begin
		if (wordValid)
			shiftReg <= word;
		else if (periodEnd)
			shiftReg <= {shiftReg[`ADC_WORD_W-2:0], 1'b0};
	end

	// sequencer waits for wordDone, so a new word only comes with select high
	noWordWhileSending: assert property (@(posedge clk) disable iff (rst)
		wordValid |-> select);

endmodule

// File: runSim.sh
#!/usr/bin/env bash
# build and run the adcCfg testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f adcCfgTop.f --top-module adcCfgTb -o adcCfgSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/adcCfgSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// File: tbClockGen.sv
`timescale 1ns/10ps

// free running clock and a synchronous reset for the testbench
module tbClockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk); // held for four rising edges
		rst <= 1'b0;
	end

endmodule
